// File: project.f
+incdir+hdl
hdl/mem_writer_pkg.sv
hdl/apb_regs.sv
hdl/stream_fifo.sv
hdl/burst_planner.sv
hdl/axi_write_engine.sv
hdl/stream_mem_writer.sv
sim/tb_stream_mem_writer.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --timing --assert -f project.f --top-module tb_stream_mem_writer \
    -o tb_stream_mem_writer > build.log 2>&1 &&
./obj_dir/tb_stream_mem_writer > sim.log 2>&1 ||
echo "build or simulation error, see build.log and sim.log"
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/tb_stream_mem_writer.sv
`timescale 1ns/10ps
`include "mem_writer_params.svh"

module tb_stream_mem_writer;
    import mem_writer_pkg::*;

    localparam logic [31:0] SEED = 32'he609_a5cf;
    // streamed words of all portions with the stopped one cut short
    localparam int TOTAL_WORDS = 40 * 4 + 8 + 100 + 37 + 64;

    logic                    CLK;
    logic                    RESET;
    apb_req_t                apb;
    logic [31:0]             prdata;
    logic                    pready, pslverr, irq;
    logic [`MW_DATA_W-1:0]   s_tdata;
    logic                    s_tvalid, s_tready;
    logic [`MW_ADDR_W-1:0]   m_awaddr;
    logic [7:0]              m_awlen;
    logic [2:0]              m_awsize, m_awprot;
    logic [1:0]              m_awburst, m_bresp;
    logic [3:0]              m_awcache;
    logic                    m_awlock, m_awvalid, m_awready;
    logic [`MW_DATA_W-1:0]   m_wdata;
    logic [`MW_DATA_W/8-1:0] m_wstrb;
    logic                    m_wlast, m_wvalid, m_wready;
    logic                    m_bvalid, m_bready;

    logic [31:0] mem [logic [31:0]];   // slave memory
    logic [31:0] tx_q[$];              // words not yet taken by the DUT
    logic [31:0] exp_aw[$], exp_len[$], exp_waddr[$], exp_data[$];
    logic [31:0] snap_addr[$], snap_data[$];
    logic [31:0] exp_ptr, ring_base, ring_high, data_rng, stall_rng, wr_addr;
    logic        stall, s_fired, b_pend;
    int          n_checks = 0;
    int          n_errors = 0;
    int          beats_seen, bursts_seen, burst_beats, beat;

    stream_mem_writer dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // expected bursts of one portion and the pointer it leaves behind
    function automatic logic [31:0] plans_bursts(input logic [31:0] start, input int words);
        logic [31:0] p;
        int          rem;
        int          n;
        int          to_bound;
        p = (start < ring_base || start >= ring_high) ? ring_base : start;
        rem = words;
        while (rem > 0) begin
            to_bound = (`MW_BOUND_BYTES - int'(p % `MW_BOUND_BYTES)) / 4;
            n = `MW_BURST_LIMIT;
            if (rem < n) n = rem;
            if (to_bound < n) n = to_bound;
            exp_aw.push_back(p);
            exp_len.push_back(32'(n - 1));
            for (int i = 0; i < n; i++) exp_waddr.push_back(p + 32'(4 * i));
            p = p + 32'(4 * n);
            rem = rem - n;
        end
        return (p >= ring_high) ? ring_base : p;   // ring wrap at portion end
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge CLK);
        apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge CLK);
        apb.penable = 1'b1;
        @(negedge CLK);   // no wait states expected
        rdata = prdata;
        err = pslverr;
        check_eq(32'(pready), 32'd1, "APB pready");
        apb = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_eq(32'(err), 32'd0, "APB write slave error");
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, 32'd0, rdata, err);
        check_eq(rdata, exp, what);
        check_eq(32'(err), 32'(addr > 8'h18), "APB read slave error");
    endtask

    task automatic set_ring(input logic [31:0] base, input logic [31:0] high);
        ring_base = base;
        ring_high = high;
        apb_write(BASE, base);
        apb_write(HIGH, high);
        read_expect(BASE, base, "BASE readback");
        read_expect(HIGH, high, "HIGH readback");
    endtask

    task automatic load_portion(input int bytes);
        int words;
        words = (bytes + 3) / 4;
        apb_write(PORTION, 32'(bytes));
        read_expect(PORTION, 32'(bytes), "PORTION readback");
        exp_ptr = plans_bursts(exp_ptr, words);
        snap_addr = exp_waddr;
        snap_data = {};
        beats_seen = 0;
        bursts_seen = 0;
        burst_beats = 0;
        for (int i = 0; i < words; i++) begin
            data_rng = xorshift(data_rng);
            tx_q.push_back(data_rng);
            exp_data.push_back(data_rng);
            snap_data.push_back(data_rng);
        end
    endtask

    task automatic check_memory(input int n);
        for (int i = 0; i < n; i++)
            check_eq(mem.exists(snap_addr[i]) ? mem[snap_addr[i]] : 32'hxxxx_xxxx,
                     snap_data[i], "memory word");
    endtask

    task automatic run_portion(input int bytes);
        int words;
        words = (bytes + 3) / 4;
        load_portion(bytes);
        apb_write(CTRL, 32'd1);
        while (!irq) @(negedge CLK);
        check_eq(32'(exp_aw.size()), 32'd0, "bursts left unissued");
        read_expect(XFER_BYTES, 32'(words * 4), "XFER_BYTES");
        read_expect(CUR_ADDR, exp_ptr, "CUR_ADDR");
        check_memory(words);
        read_expect(STATUS, 32'd2, "STATUS done");
        check_eq(32'(irq), 32'd1, "irq set");
        apb_write(STATUS, 32'd2);   // write 1 to clear done
        read_expect(STATUS, 32'd0, "STATUS cleared");
        check_eq(32'(irq), 32'd0, "irq cleared");
    endtask

    task automatic stop_portion();
        int n;
        set_ring(32'h0001_0000, 32'h0002_0000);
        load_portion(4000);
        apb_write(CTRL, 32'd1);
        while (bursts_seen < 3) @(negedge CLK);
        apb_write(CTRL, 32'd2);
        while (!irq) @(negedge CLK);
        n = bursts_seen;
        repeat (100) @(negedge CLK);
        check_eq(32'(bursts_seen), 32'(n), "burst after stop");
        check_eq(32'(beats_seen), 32'(burst_beats), "beats of issued bursts");
        read_expect(STATUS, 32'd2, "STATUS after stop");
        read_expect(XFER_BYTES, 32'(beats_seen * 4), "XFER_BYTES after stop");
        read_expect(CUR_ADDR, 32'h0001_0000 + 32'(beats_seen * 4), "CUR_ADDR after stop");
        check_memory(beats_seen);
        check_eq(32'(mem.exists(snap_addr[beats_seen])), 32'd0, "word written past stop");
    endtask

    // stream source and slave ready/valid driven on the falling edge
    initial begin
        s_tvalid = 1'b0;
        s_tdata = '0;
        m_awready = 1'b0;
        m_wready = 1'b0;
        m_bvalid = 1'b0;
        m_bresp = 2'b00;
        s_fired = 1'b0;
        b_pend = 1'b0;
        stall_rng = xorshift(SEED);
        forever begin
            @(negedge CLK);
            stall_rng = xorshift(stall_rng);
            m_awready = !stall || stall_rng[1:0] != 2'd0;
            m_wready = !stall || stall_rng[3:2] != 2'd0;
            m_bvalid = b_pend && (m_bvalid || !stall || stall_rng[5:4] != 2'd0);
            if (tx_q.size() == 0) begin
                s_tvalid = 1'b0;
            end else if (!s_tvalid || s_fired) begin   // hold valid until taken
                s_tvalid = !stall || stall_rng[7:6] != 2'd0;
                s_tdata = tx_q[0];
            end
        end
    end

    // handshakes seen on the rising edge and compared with the reference
    always @(posedge CLK) begin
        s_fired = s_tvalid && s_tready;
        if (s_fired) void'(tx_q.pop_front());
        if (m_awvalid && m_awready) begin
            bursts_seen++;
            burst_beats += int'(m_awlen) + 1;
            wr_addr = m_awaddr;
            beat = 0;
            check_eq(32'(int'(m_awaddr % `MW_BOUND_BYTES) + 4 * (int'(m_awlen) + 1) >
                     `MW_BOUND_BYTES), 32'd0, "burst crosses 4 KB");
            check_eq(32'({m_awsize, m_awburst}), 32'({3'd2, 2'b01}), "AW size and type");
            check_eq(32'({m_awlock, m_awcache, m_awprot}), 32'd0, "AW lock, cache and prot");
            if (exp_aw.size() == 0) begin
                n_errors++;
                $display("a burst to %h was issued that the reference does not expect", m_awaddr);
            end else begin
                check_eq(m_awaddr, exp_aw.pop_front(), "AW address");
                check_eq(32'(m_awlen), exp_len.pop_front(), "AW length");
            end
        end
        if (m_wvalid && m_wready) begin
            mem[wr_addr] = m_wdata;
            check_eq(wr_addr, exp_waddr.pop_front(), "W address");
            check_eq(m_wdata, exp_data.pop_front(), "W data");
            check_eq(32'(m_wlast), 32'(beat == int'(m_awlen)), "WLAST");
            check_eq(32'(m_wstrb), 32'hf, "WSTRB");
            wr_addr = wr_addr + 32'd4;
            beat++;
            beats_seen++;
            if (m_wlast) b_pend = 1'b1;
        end
        if (m_bvalid && m_bready) b_pend = 1'b0;
    end

    initial begin
        repeat (TOTAL_WORDS * 40 + 2000) @(posedge CLK);
        $display("timeout: the DUT did not finish the tests in time, %0d errors so far", n_errors);
        $display("tests failed");
        $finish;
    end

    initial begin
        apb = '0;
        RESET = 1'b1;
        stall = 1'b0;
        data_rng = SEED;
        exp_ptr = '0;
        repeat (8) @(negedge CLK);
        RESET = 1'b0;
        check_eq(32'({m_awvalid, m_wvalid, m_bready, s_tready, irq}), 32'd0, "after reset");
        read_expect(STATUS, 32'd0, "STATUS after reset");
        read_expect(8'h40, 32'd0, "unmapped offset");
        set_ring(32'h0000_1000, 32'h0000_8000);
        run_portion(160);                          // 16 16 8
        set_ring(32'h0000_1FE8, 32'h0000_8000);
        run_portion(160);                          // 6 beats up to the boundary
        set_ring(32'h0000_3000, 32'h0000_3100);
        run_portion(160);
        run_portion(160);                          // runs past HIGH and wraps
        run_portion(32);
        stall = 1'b1;
        set_ring(32'h0000_4F80, 32'h0000_6000);
        run_portion(400);
        run_portion(146);                          // rounds up to 37 words
        stall = 1'b0;
        stop_portion();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: hdl/stream_mem_writer.sv
`timescale 1ns/10ps
`include "mem_writer_params.svh"

module stream_mem_writer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  mem_writer_pkg::apb_req_t  apb,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic [`MW_DATA_W-1:0]     s_tdata,
    input  logic                      s_tvalid,
    output logic                      s_tready,
    output logic [`MW_ADDR_W-1:0]     m_awaddr,
    output logic [7:0]                m_awlen,
    output logic [2:0]                m_awsize,
    output logic [1:0]                m_awburst,
    output logic                      m_awlock,
    output logic [3:0]                m_awcache,
    output logic [2:0]                m_awprot,
    output logic                      m_awvalid,
    input  logic                      m_awready,
    output logic [`MW_DATA_W-1:0]     m_wdata,
    output logic [`MW_DATA_W/8-1:0]   m_wstrb,
    output logic                      m_wlast,
    output logic                      m_wvalid,
    input  logic                      m_wready,
    input  logic [1:0]                m_bresp,
    input  logic                      m_bvalid,
    output logic                      m_bready,
    output logic                      irq
);
    import mem_writer_pkg::*;

    mw_cfg_t                         cfg;
    mw_stat_t                        stat;
    burst_cmd_t                      cmd;
    logic                            run;
    logic                            stop;
    logic                            cmd_valid;
    logic                            cmd_ready;
    logic                            burst_done;
    logic                            fifo_open;
    logic                            fifo_flush;
    logic                            pop;
    logic [$clog2(`MW_FIFO_DEPTH):0] fifo_count;
    logic [`MW_DATA_W-1:0]           fifo_head;

    apb_regs regs_i (
        .CLK(CLK), .RESET(RESET), .apb(apb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .cfg(cfg), .run(run), .stop(stop), .stat(stat), .irq(irq)
    );

    stream_fifo fifo_i (
        .CLK(CLK), .RESET(RESET), .flush(fifo_flush), .open(fifo_open),
        .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready),
        .head(fifo_head), .pop(pop), .count(fifo_count)
    );

    burst_planner planner_i (
        .CLK(CLK), .RESET(RESET), .cfg(cfg), .run(run), .stop(stop),
        .fifo_count(fifo_count), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .burst_done(burst_done), .stat(stat), .fifo_open(fifo_open), .fifo_flush(fifo_flush)
    );

    axi_write_engine engine_i (
        .CLK(CLK), .RESET(RESET), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .burst_done(burst_done), .fifo_head(fifo_head), .pop(pop),
        .m_awaddr(m_awaddr), .m_awlen(m_awlen), .m_awsize(m_awsize), .m_awburst(m_awburst),
        .m_awlock(m_awlock), .m_awcache(m_awcache), .m_awprot(m_awprot),
        .m_awvalid(m_awvalid), .m_awready(m_awready),
        .m_wdata(m_wdata), .m_wstrb(m_wstrb), .m_wlast(m_wlast), .m_wvalid(m_wvalid),
        .m_wready(m_wready), .m_bresp(m_bresp), .m_bvalid(m_bvalid), .m_bready(m_bready)
    );

endmodule

// File: hdl/axi_write_engine.sv
`timescale 1ns/10ps
`include "mem_writer_params.svh"

module axi_write_engine (
    input  logic                         CLK,
    input  logic                         RESET,
    input  mem_writer_pkg::burst_cmd_t   cmd,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    output logic                         burst_done,
    input  logic [`MW_DATA_W-1:0]        fifo_head,
    output logic                         pop,
    output logic [`MW_ADDR_W-1:0]        m_awaddr,
    output logic [7:0]                   m_awlen,
    output logic [2:0]                   m_awsize,
    output logic [1:0]                   m_awburst,
    output logic                         m_awlock,
    output logic [3:0]                   m_awcache,
    output logic [2:0]                   m_awprot,
    output logic                         m_awvalid,
    input  logic                         m_awready,
    output logic [`MW_DATA_W-1:0]        m_wdata,
    output logic [`MW_DATA_W/8-1:0]      m_wstrb,
    output logic                         m_wlast,
    output logic                         m_wvalid,
    input  logic                         m_wready,
    input  logic [1:0]                   m_bresp,
    input  logic                         m_bvalid,
    output logic                         m_bready
);
    import mem_writer_pkg::*;

    wr_state_e  state;
    logic [7:0] beat;

    assign cmd_ready  = state == IDLE;
    assign m_awvalid  = state == ADDR;
    assign m_wvalid   = state == DATA;
    assign m_bready   = state == RESP;
    assign m_wlast    = m_wvalid && beat == m_awlen;
    assign m_wdata    = fifo_head;
    assign pop        = m_wvalid && m_wready;   // one word per beat
    assign burst_done = m_bvalid && m_bready;

    assign m_awsize  = 3'($clog2(`MW_DATA_W / 8));
    assign m_awburst = 2'b01;   // incr
    assign m_awlock  = 1'b0;
    assign m_awcache = '0;
    assign m_awprot  = '0;
    assign m_wstrb   = '1;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            case (state)
                IDLE: if (cmd_valid) state <= ADDR;
                ADDR: if (m_awready) state <= DATA;
                DATA: if (m_wready && m_wlast) state <= RESP;
                RESP: if (m_bvalid) state <= IDLE;
                default: state <= IDLE;
            endcase
            if (state != DATA) beat <= '0;
            else if (m_wready) beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd_valid && cmd_ready) begin
            m_awaddr <= cmd.addr;
            m_awlen  <= cmd.len;
        end
    end

    assert property (@(posedge CLK) disable iff (RESET)
        m_awvalid |-> m_awlen <= 8'(`MW_BURST_LIMIT - 1));

    assert property (@(posedge CLK) disable iff (RESET)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr) && $stable(m_awlen));

    // slave is expected to answer OKAY
    assert property (@(posedge CLK) disable iff (RESET)
        burst_done |-> m_bresp == 2'b00);

endmodule

// File: hdl/burst_planner.sv
`timescale 1ns/10ps
`include "mem_writer_params.svh"

module burst_planner (
    input  logic                            CLK,
    input  logic                            RESET,
    input  mem_writer_pkg::mw_cfg_t         cfg,
    input  logic                            run,
    input  logic                            stop,
    input  logic [$clog2(`MW_FIFO_DEPTH):0] fifo_count,
    output mem_writer_pkg::burst_cmd_t      cmd,
    output logic                            cmd_valid,
    input  logic                            cmd_ready,
    input  logic                            burst_done,
    output mem_writer_pkg::mw_stat_t        stat,
    output logic                            fifo_open,
    output logic                            fifo_flush
);

    localparam int                    WORD_SHIFT = $clog2(`MW_DATA_W / 8);
    localparam int                    BOUND_BITS = $clog2(`MW_BOUND_BYTES);
    localparam int                    TIMER_W    = $clog2(`MW_ACCUM_LIMIT + 1);
    localparam logic [BOUND_BITS:0]   BOUND      = `MW_BOUND_BYTES;
    localparam logic [TIMER_W-1:0]    ACCUM      = `MW_ACCUM_LIMIT;

    logic                            busy;
    logic                            pending;   // command raised or burst on the bus
    logic                            stop_pending;
    logic [`MW_ADDR_W-1:0]           ptr;
    logic [31:0]                     remaining;
    logic [31:0]                     xfer_bytes;
    logic [TIMER_W-1:0]              timer;
    logic [$clog2(`MW_FIFO_DEPTH):0] last_count;
    logic [BOUND_BITS:0]             bytes_to_bound;
    logic [31:0]                     bound_words;
    logic [31:0]                     need;
    logic [31:0]                     take;
    logic [8:0]                      beats;
    logic [`MW_ADDR_W-1:0]           ptr_next;
    logic [31:0]                     rem_after;
    logic                            timed_out;
    logic                            launch;
    logic                            finish;

    assign bytes_to_bound = BOUND - {1'b0, ptr[BOUND_BITS-1:0]};
    assign bound_words    = 32'(bytes_to_bound[BOUND_BITS:WORD_SHIFT]);
    assign beats          = {1'b0, cmd.len} + 9'd1;
    assign ptr_next       = ptr + (`MW_ADDR_W'(beats) << WORD_SHIFT);
    assign rem_after      = remaining - 32'(beats);
    assign timed_out      = timer == ACCUM && fifo_count != 0;

    // smallest of burst limit, words left, words to boundary, fifo fill
    always_comb begin
        need = `MW_BURST_LIMIT;
        if (remaining < need) need = remaining;
        if (bound_words < need) need = bound_words;
        take = need;
        if (32'(fifo_count) < take) take = 32'(fifo_count);
    end

    assign launch = busy && !pending && !stop_pending && !stop && remaining != 0 &&
                    (32'(fifo_count) >= need || timed_out);
    assign finish = busy && ((burst_done && (rem_after == 0 || stop_pending)) ||
                             (stop_pending && !pending));

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy         <= 1'b0;
            pending      <= 1'b0;
            stop_pending <= 1'b0;
            cmd_valid    <= 1'b0;
            timer        <= '0;
        end else begin
            if (!busy && run) busy <= 1'b1;
            else if (finish) busy <= 1'b0;
            if (finish || !busy) stop_pending <= 1'b0;
            else if (stop) stop_pending <= 1'b1;
            if (launch) pending <= 1'b1;
            else if (burst_done) pending <= 1'b0;
            if (launch) cmd_valid <= 1'b1;
            else if (cmd_ready) cmd_valid <= 1'b0;
            // restarts whenever the fifo level moves
            if (!busy || pending || fifo_count == 0 || fifo_count != last_count) timer <= '0;
            else if (timer != ACCUM) timer <= timer + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            ptr        <= '0;
            remaining  <= '0;
            xfer_bytes <= '0;
        end else if (!busy && run) begin
            remaining  <= cfg.portion_words;
            xfer_bytes <= '0;
            if (ptr < cfg.base || ptr >= cfg.high) ptr <= cfg.base;  // outside the ring
        end else if (burst_done) begin
            remaining  <= rem_after;
            xfer_bytes <= xfer_bytes + (32'(beats) << WORD_SHIFT);
            if (finish && ptr_next >= cfg.high) ptr <= cfg.base;
            else ptr <= ptr_next;
        end
    end

    always_ff @(posedge CLK) begin
        last_count <= fifo_count;
        if (launch) begin
            cmd.addr <= ptr;
            cmd.len  <= 8'(take - 1);
        end
    end

    assign stat.busy       = busy;
    assign stat.done       = finish;
    assign stat.cur_addr   = ptr;
    assign stat.xfer_bytes = xfer_bytes;
    assign fifo_open       = busy;
    assign fifo_flush      = finish && stop_pending;   // drop words left after a stop

    assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid && cmd_ready |->
            int'(cmd.addr[BOUND_BITS-1:0]) + (int'(beats) << WORD_SHIFT) <= `MW_BOUND_BYTES);

endmodule

// File: hdl/stream_fifo.sv
`timescale 1ns/10ps
`include "mem_writer_params.svh"

module stream_fifo (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            flush,
    input  logic                            open,
    input  logic [`MW_DATA_W-1:0]           s_tdata,
    input  logic                            s_tvalid,
    output logic                            s_tready,
    output logic [`MW_DATA_W-1:0]           head,
    input  logic                            pop,
    output logic [$clog2(`MW_FIFO_DEPTH):0] count
);

    localparam int            PTR_W = $clog2(`MW_FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL = `MW_FIFO_DEPTH;

    logic [`MW_DATA_W-1:0] mem [`MW_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic                  push;

    assign s_tready = open && count != FULL;
    assign push     = s_tvalid && s_tready;
    assign head     = mem[rd_ptr];   // first word falls through

    always_ff @(posedge CLK) begin
        if (push) mem[wr_ptr] <= s_tdata;
    end

    always_ff @(posedge CLK) begin
        if (RESET || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // engine never reads beyond what the planner saw
    assert property (@(posedge CLK) disable iff (RESET)
        pop |-> count != 0);

endmodule

// File: hdl/apb_regs.sv
`timescale 1ns/10ps
`include "mem_writer_params.svh"

module apb_regs (
    input  logic                      CLK,
    input  logic                      RESET,
    input  mem_writer_pkg::apb_req_t  apb,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output mem_writer_pkg::mw_cfg_t   cfg,
    output logic                      run,
    output logic                      stop,
    input  mem_writer_pkg::mw_stat_t  stat,
    output logic                      irq
);
    import mem_writer_pkg::*;

    localparam int WORD_SHIFT = $clog2(`MW_DATA_W / 8);

    reg_addr_e   addr;
    logic        wr_en;
    logic        unmapped;
    logic        done_r;
    logic [31:0] portion_bytes;

    assign addr    = reg_addr_e'(apb.paddr);
    assign wr_en   = apb.psel && apb.penable && apb.pwrite;
    assign pready  = 1'b1;   // no wait states
    assign pslverr = apb.psel && apb.penable && unmapped;
    assign irq     = done_r;

    always_comb begin
        prdata   = '0;
        unmapped = 1'b0;
        case (addr)
            CTRL:       ;                       // write only
            STATUS:     prdata = {30'd0, done_r, stat.busy};
            BASE:       prdata = cfg.base;
            HIGH:       prdata = cfg.high;
            PORTION:    prdata = portion_bytes;
            CUR_ADDR:   prdata = stat.cur_addr;
            XFER_BYTES: prdata = stat.xfer_bytes;
            default:    unmapped = 1'b1;
        endcase
    end

    // run/stop pulse the cycle after the access
    always_ff @(posedge CLK) begin
        if (RESET) begin
            run  <= 1'b0;
            stop <= 1'b0;
        end else begin
            run  <= wr_en && addr == CTRL && apb.pwdata[0];
            stop <= wr_en && addr == CTRL && apb.pwdata[1];
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            cfg           <= '0;
            portion_bytes <= '0;
        end else if (wr_en) begin
            case (addr)
                BASE: cfg.base <= apb.pwdata;
                HIGH: cfg.high <= apb.pwdata;
                PORTION: begin
                    portion_bytes     <= apb.pwdata;
                    cfg.portion_words <= (apb.pwdata >> WORD_SHIFT) +
                                         32'(apb.pwdata[WORD_SHIFT-1:0] != 0);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) done_r <= 1'b0;
        else if (stat.done) done_r <= 1'b1;     // set wins over clear
        else if (wr_en && addr == STATUS && apb.pwdata[1]) done_r <= 1'b0;
    end

    // access phase must follow a setup phase
    assert property (@(posedge CLK) disable iff (RESET)
        apb.penable |-> apb.psel && $past(apb.psel));

endmodule

// File: hdl/mem_writer_pkg.sv
`include "mem_writer_params.svh"

package mem_writer_pkg;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } wr_state_e;

    typedef enum logic [`MW_APB_ADDR_W-1:0] {
        CTRL       = 8'h00,
        STATUS     = 8'h04,
        BASE       = 8'h08,
        HIGH       = 8'h0C,
        PORTION    = 8'h10,
        CUR_ADDR   = 8'h14,
        XFER_BYTES = 8'h18
    } reg_addr_e;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`MW_APB_ADDR_W-1:0] paddr;
        logic [`MW_DATA_W-1:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`MW_ADDR_W-1:0] base;
        logic [`MW_ADDR_W-1:0] high;
        logic [31:0]           portion_words;   // bytes rounded up
    } mw_cfg_t;

    typedef struct packed {
        logic                  busy;
        logic                  done;            // single cycle
        logic [`MW_ADDR_W-1:0] cur_addr;
        logic [31:0]           xfer_bytes;
    } mw_stat_t;

    typedef struct packed {
        logic [`MW_ADDR_W-1:0] addr;
        logic [7:0]            len;             // beats minus one
    } burst_cmd_t;

endpackage

// File: hdl/mem_writer_params.svh
`ifndef MEM_WRITER_PARAMS_SVH
`define MEM_WRITER_PARAMS_SVH

`define MW_DATA_W      32
`define MW_ADDR_W      32
`define MW_BURST_LIMIT 16   // beats
`define MW_FIFO_DEPTH  32   // two full bursts of words
// idle cycles before a partial burst goes out
`define MW_ACCUM_LIMIT 64
`define MW_BOUND_BYTES 4096
`define MW_APB_ADDR_W  8

`endif
